// ==== sim.f ====
+incdir+verification
common/calc_pkg.sv
verilog/sm_addsub.sv
verilog/sm_multiply.sv
gencon/gencon.sv
verification/calc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module calc_tb -f sim.f -o calc_sim &&
./obj_dir/calc_sim | tee /dev/stderr | grep -q "Regression passed" &&
echo "simulation run ok" ||
{ echo "simulation run not ok"; exit 1; }

// ==== verification/calc_model.svh ====
// reference model for the calculator: sign-magnitude add, subtract, multiply and digit entry
`ifndef CALC_MODEL_SVH
`define CALC_MODEL_SVH

// sign-magnitude word as a plain signed number
function automatic int to_signed_int(input logic [WORD_W-1:0] w);
    int mag;
    mag = int'(w[MAG_W-1:0]);
    return w[WORD_W-1] ? -mag : mag;
endfunction

// back to sign-magnitude, magnitude wraps at 15 bits and zero is positive
function automatic logic [WORD_W-1:0] from_signed_int(input int v);
    int                mag;
    logic [WORD_W-1:0] w;
    mag = (v < 0) ? -v : v;
    mag = mag % (1 << MAG_W);
    w[MAG_W-1:0] = mag[MAG_W-1:0];
    w[WORD_W-1]  = (v < 0) && (mag != 0);
    return w;
endfunction

function automatic logic [WORD_W-1:0] toggle_sign(input logic [WORD_W-1:0] w);
    return {~w[WORD_W-1], w[MAG_W-1:0]};
endfunction

// times ten plus the digit, the entered sign is kept
function automatic logic [WORD_W-1:0] append_digit(input logic [WORD_W-1:0] w, input int digit);
    int mag;
    mag = (int'(w[MAG_W-1:0]) * 10 + digit) % (1 << MAG_W);
    return {w[WORD_W-1], mag[MAG_W-1:0]};
endfunction

function automatic logic [WORD_W-1:0] apply_operator(input calc_op_t op,
                                                     input logic [WORD_W-1:0] a,
                                                     input logic [WORD_W-1:0] b);
    case (op)
        OP_ADD:  return from_signed_int(to_signed_int(a) + to_signed_int(b));
        OP_SUB:  return from_signed_int(to_signed_int(a) - to_signed_int(b));
        OP_MUL:  return from_signed_int(to_signed_int(a) * to_signed_int(b));
        default: return '0;
    endcase
endfunction

`endif

// ==== verification/calc_tb.sv ====
// testbench for the keypad calculator, key sequences checked against a reference model
`timescale 1ns/1ps

module calc_tb;
    import calc_pkg::*;

    `include "calc_model.svh"

    logic               clk;
    logic               nRST;
    logic [DIGIT_W-1:0] keypad_input;
    logic               read_input;
    calc_op_t           operator_input;
    logic               equal_input;
    logic               complete;
    logic [WORD_W-1:0]  display_output;

    // model of what the DUT should hold
    logic [WORD_W-1:0]  exp_op1;
    logic [WORD_W-1:0]  exp_op2;
    logic [WORD_W-1:0]  exp_result;
    calc_op_t           exp_opr;
    logic               entering_op2;
    logic               calc_started;
    int                 check_errors;
    int                 timeout_errors;
    int                 seed;

    gencon dut_i (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // result held after the completion strobe
    assert property (@(posedge clk) disable iff (!nRST)
        complete |=> (display_output == exp_result))
        else begin
            check_errors++;
            $display("CHECK FAILED at %0t: display_output %h, expected %h",
                     $time, display_output, exp_result);
        end

    // quiet outputs until the first calculation
    assert property (@(posedge clk) disable iff (!nRST)
        !calc_started |-> (!complete && (display_output == '0)))
        else begin
            check_errors++;
            $display("CHECK FAILED at %0t: output active before the first equal key", $time);
        end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic calc_op_t pick_arith();
        case (rand_below(3))
            0:       return OP_ADD;
            1:       return OP_SUB;
            default: return OP_MUL;
        endcase
    endfunction

    // one key while the DUT is busy, it must have no effect
    task automatic inject_busy_key();
        case (rand_below(4))
            0: begin
                keypad_input = DIGIT_W'(rand_below(10));
                read_input   = 1'b1;
            end
            1: operator_input = OP_NEG;
            2: operator_input = pick_arith();
            default: equal_input = 1'b1;
        endcase
        @(negedge clk);
        read_input     = 1'b0;
        operator_input = OP_NONE;
        equal_input    = 1'b0;
    endtask

    task automatic press_digit(input int digit, input bit add_noise);
        keypad_input = DIGIT_W'(digit);
        read_input   = 1'b1;
        @(negedge clk);
        read_input = 1'b0;
        if (entering_op2) begin
            exp_op2 = append_digit(exp_op2, digit);
        end else begin
            exp_op1 = append_digit(exp_op1, digit);
        end
        repeat (4) @(negedge clk);
        if (add_noise) begin
            inject_busy_key();
        end else begin
            @(negedge clk);
        end
        repeat (14) @(negedge clk);
    endtask

    task automatic press_operator(input calc_op_t op);
        operator_input = op;
        @(negedge clk);
        operator_input = OP_NONE;
        if (op == OP_NEG) begin
            if (entering_op2) begin
                exp_op2 = toggle_sign(exp_op2);
            end else begin
                exp_op1 = toggle_sign(exp_op1);
            end
        end else if (!entering_op2) begin
            exp_opr      = op;
            entering_op2 = 1'b1;
        end
        repeat (19) @(negedge clk);
    endtask

    task automatic wait_for_complete();
        int cycles;
        cycles = 0;
        while (!complete && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (!complete) begin
            timeout_errors++;
            $display("ERROR at %0t: no complete strobe within 200 cycles of the equal key", $time);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic press_equal(input bit add_noise);
        equal_input = 1'b1;
        if (entering_op2) begin
            exp_result   = apply_operator(exp_opr, exp_op1, exp_op2);
            calc_started = 1'b1;
        end
        @(negedge clk);
        equal_input = 1'b0;
        if (entering_op2) begin
            if (add_noise) begin
                inject_busy_key();
            end
            wait_for_complete();
            // operands and operator clear after each result
            exp_op1      = '0;
            exp_op2      = '0;
            exp_opr      = OP_NONE;
            entering_op2 = 1'b0;
        end else begin
            repeat (19) @(negedge clk);
        end
    endtask

    // most significant digit first
    task automatic enter_digits(input int value);
        int digits[$];
        int v;
        v = value;
        do begin
            digits.push_front(v % 10);
            v = v / 10;
        end while (v > 0);
        foreach (digits[i]) begin
            press_digit(digits[i], 1'b0);
        end
    endtask

    task automatic run_calculation(input int a, input bit neg_a, input calc_op_t op,
                                   input int b, input bit neg_b);
        if (neg_a) begin
            press_operator(OP_NEG);
        end
        enter_digits(a);
        press_operator(op);
        if (neg_b) begin
            press_operator(OP_NEG);
        end
        enter_digits(b);
        press_equal(1'b0);
    endtask

    task automatic random_calculation();
        int count;
        if (rand_below(2) == 1) begin
            press_operator(OP_NEG);
        end
        count = 1 + rand_below(4);
        repeat (count) press_digit(rand_below(10), rand_below(2) == 1);
        // equal during the first operand is ignored
        if (rand_below(2) == 1) begin
            press_equal(1'b0);
        end
        press_operator(pick_arith());
        // a second operator is ignored
        if (rand_below(2) == 1) begin
            press_operator(pick_arith());
        end
        if (rand_below(2) == 1) begin
            press_operator(OP_NEG);
        end
        count = 1 + rand_below(4);
        repeat (count) press_digit(rand_below(10), rand_below(2) == 1);
        press_equal(1'b1);
    endtask

    initial begin
        seed           = 32'h5f1e_c2c3;
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = OP_NONE;
        equal_input    = 1'b0;
        exp_op1        = '0;
        exp_op2        = '0;
        exp_result     = '0;
        exp_opr        = OP_NONE;
        entering_op2   = 1'b0;
        calc_started   = 1'b0;
        check_errors   = 0;
        timeout_errors = 0;
        repeat (3) @(negedge clk);
        nRST = 1'b1;
        repeat (2) @(negedge clk);

        // 123 + 45, with an early equal that must be ignored
        press_digit(1, 1'b0);
        press_equal(1'b0);
        run_calculation(23, 1'b0, OP_ADD, 45, 1'b0);

        run_calculation(7, 1'b0, OP_SUB, 250, 1'b0);
        run_calculation(250, 1'b0, OP_SUB, 250, 1'b0);
        run_calculation(12, 1'b1, OP_ADD, 5, 1'b0);
        run_calculation(30, 1'b0, OP_SUB, 40, 1'b1);

        // double negate leaves the first operand positive
        press_operator(OP_NEG);
        press_operator(OP_NEG);
        run_calculation(9, 1'b0, OP_ADD, 3, 1'b1);

        run_calculation(12, 1'b1, OP_MUL, 34, 1'b0);
        run_calculation(300, 1'b0, OP_MUL, 200, 1'b0);
        run_calculation(250, 1'b1, OP_MUL, 250, 1'b1);

        repeat (20) random_calculation();
        repeat (4) @(negedge clk);

        $display("closing report: %0d check failures, %0d timeouts",
                 check_errors, timeout_errors);
        if (check_errors + timeout_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== gencon/gencon.sv ====
// keypad calculator controller: operand entry, operator latch, unit dispatch and result display
`timescale 1ns/1ps

module gencon (
    input  logic                         clk,
    input  logic                         nRST,
    input  logic [calc_pkg::DIGIT_W-1:0] keypad_input,
    input  logic                         read_input,
    input  calc_pkg::calc_op_t           operator_input,
    input  logic                         equal_input,
    output logic                         complete,
    output logic [calc_pkg::WORD_W-1:0]  display_output
);
    import calc_pkg::*;

    calc_state_t state;
    calc_state_t next_state;
    calc_op_t    op_q;

    logic [WORD_W-1:0]  operand1;
    logic [WORD_W-1:0]  operand2;
    logic [DIGIT_W-1:0] digit_q;
    logic [MAG_W-1:0]   digit_ext;
    logic               arith_key;
    logic               digit_load;

    logic [WORD_W-1:0]  addsub_a;
    logic [WORD_W-1:0]  addsub_b;
    logic [WORD_W-1:0]  addsub_result;
    logic               addsub_sub;
    logic               addsub_start;
    logic               addsub_finish;

    logic [WORD_W-1:0]  mult_a;
    logic [WORD_W-1:0]  mult_b;
    logic [WORD_W-1:0]  mult_product;
    logic               mult_start;
    logic               mult_finish;

    logic               unit_finish;
    logic [WORD_W-1:0]  unit_result;

    assign arith_key = (operator_input == OP_ADD) || (operator_input == OP_SUB) ||
                       (operator_input == OP_MUL);
    assign digit_ext = {{(MAG_W - DIGIT_W){1'b0}}, digit_q};

    // the adder always sees the two operands
    assign addsub_a   = operand1;
    assign addsub_b   = operand2;
    assign addsub_sub = (op_q == OP_SUB);

    // pick the unit that the latched operator started
    assign unit_finish = (op_q == OP_MUL) ? mult_finish : addsub_finish;
    assign unit_result = (op_q == OP_MUL) ? mult_product : addsub_result;

    sm_addsub add_calc (
        .clk    (clk),
        .nRST   (nRST),
        .a      (addsub_a),
        .b      (addsub_b),
        .sub    (addsub_sub),
        .start  (addsub_start),
        .result (addsub_result),
        .finish (addsub_finish)
    );

    sm_multiply mult_calc (
        .clk     (clk),
        .nRST    (nRST),
        .a       (mult_a),
        .b       (mult_b),
        .start   (mult_start),
        .product (mult_product),
        .finish  (mult_finish)
    );

    // next state and unit strobes
    always_comb begin
        next_state   = state;
        mult_a       = operand1;
        mult_b       = WORD_W'(DIGIT_BASE);
        mult_start   = 1'b0;
        addsub_start = 1'b0;
        digit_load   = 1'b0;

        case (state)
            ENTER_OP1: begin
                if (arith_key) begin
                    next_state = ENTER_OP2;
                end else if (read_input) begin
                    digit_load = 1'b1;
                    mult_start = 1'b1;
                    next_state = WAIT_SHIFT_OP1;
                end
            end
            WAIT_SHIFT_OP1: begin
                if (mult_finish) begin
                    next_state = ADD_DIGIT_OP1;
                end
            end
            ADD_DIGIT_OP1: next_state = ENTER_OP1;
            ENTER_OP2: begin
                mult_a = operand2;
                if (equal_input) begin
                    next_state = DISPATCH;
                end else if (read_input) begin
                    digit_load = 1'b1;
                    mult_start = 1'b1;
                    next_state = WAIT_SHIFT_OP2;
                end
            end
            WAIT_SHIFT_OP2: begin
                if (mult_finish) begin
                    next_state = ADD_DIGIT_OP2;
                end
            end
            ADD_DIGIT_OP2: next_state = ENTER_OP2;
            DISPATCH: begin
                if (op_q == OP_MUL) begin
                    mult_a     = operand1;
                    mult_b     = operand2;
                    mult_start = 1'b1;
                end else begin
                    addsub_start = 1'b1;
                end
                next_state = WAIT_UNIT;
            end
            WAIT_UNIT: begin
                if (unit_finish) begin
                    next_state = SHOW_RESULT;
                end
            end
            SHOW_RESULT: next_state = ENTER_OP1;
            default: next_state = ENTER_OP1;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= ENTER_OP1;
            op_q           <= OP_NONE;
            operand1       <= '0;
            operand2       <= '0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            state    <= next_state;
            complete <= (state == SHOW_RESULT);

            case (state)
                ENTER_OP1: begin
                    if (operator_input == OP_NEG) begin
                        operand1[WORD_W-1] <= ~operand1[WORD_W-1];
                    end
                    if (arith_key) begin
                        op_q <= operator_input;
                    end
                end
                // keep the entered sign, only the magnitude is shifted
                WAIT_SHIFT_OP1: begin
                    if (mult_finish) begin
                        operand1[MAG_W-1:0] <= mult_product[MAG_W-1:0];
                    end
                end
                ADD_DIGIT_OP1: operand1[MAG_W-1:0] <= operand1[MAG_W-1:0] + digit_ext;
                ENTER_OP2: begin
                    if (operator_input == OP_NEG) begin
                        operand2[WORD_W-1] <= ~operand2[WORD_W-1];
                    end
                end
                WAIT_SHIFT_OP2: begin
                    if (mult_finish) begin
                        operand2[MAG_W-1:0] <= mult_product[MAG_W-1:0];
                    end
                end
                ADD_DIGIT_OP2: operand2[MAG_W-1:0] <= operand2[MAG_W-1:0] + digit_ext;
                SHOW_RESULT: begin
                    display_output <= unit_result;
                    operand1       <= '0;
                    operand2       <= '0;
                    op_q           <= OP_NONE;
                end
                default: ;
            endcase
        end
    end

    // digit waits here while the operand is shifted
    always_ff @(posedge clk) begin
        if (digit_load) begin
            digit_q <= keypad_input;
        end
    end

    // one unit at a time, digit shifts included
    assert property (@(posedge clk) disable iff (!nRST) !(addsub_start && mult_start))
        else $error("adder and multiplier started together");

    assert property (@(posedge clk) disable iff (!nRST) complete |=> !complete)
        else $error("complete held for more than one cycle");

endmodule

// ==== verilog/sm_multiply.sv ====
// sequential shift-add sign-magnitude multiplier, one multiplier bit per cycle
`timescale 1ns/1ps

module sm_multiply (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic [calc_pkg::WORD_W-1:0] a,
    input  logic [calc_pkg::WORD_W-1:0] b,
    input  logic                        start,
    output logic [calc_pkg::WORD_W-1:0] product,
    output logic                        finish
);
    import calc_pkg::*;

    logic                  busy;
    logic [MULT_CNT_W-1:0] cyc;

    logic [MAG_W-1:0] mcand;
    logic [MAG_W-1:0] mplier;
    logic [MAG_W-1:0] acc;
    logic [MAG_W-1:0] acc_nxt;
    logic             sign_q;

    // partial product wraps at 15 bits
    assign acc_nxt = mplier[0] ? (acc + mcand) : acc;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            cyc    <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cyc  <= MULT_CNT_W'(1);
            end else if (busy) begin
                if (cyc == MULT_CNT_W'(MULT_CYCLES - 1)) begin
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end else begin
                    cyc <= cyc + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= a[MAG_W-1:0];
            mplier <= b[MAG_W-1:0];
            acc    <= '0;
            sign_q <= a[WORD_W-1] ^ b[WORD_W-1];
        end else if (busy) begin
            acc    <= acc_nxt;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            // last step also applies the sign, zero stays positive
            if (cyc == MULT_CNT_W'(MULT_CYCLES - 1)) begin
                product <= {sign_q && (acc_nxt != '0), acc_nxt};
            end
        end
    end

    assert property (@(posedge clk) disable iff (!nRST) start |-> !busy)
        else $error("sm_multiply started while busy");

    assert property (@(posedge clk) disable iff (!nRST) finish |=> !finish)
        else $error("sm_multiply finish held for more than one cycle");

endmodule

// ==== verilog/sm_addsub.sv ====
// sign-magnitude adder/subtractor, operands registered then combined
`timescale 1ns/1ps

module sm_addsub (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic [calc_pkg::WORD_W-1:0] a,
    input  logic [calc_pkg::WORD_W-1:0] b,
    input  logic                        sub,
    input  logic                        start,
    output logic [calc_pkg::WORD_W-1:0] result,
    output logic                        finish
);
    import calc_pkg::*;

    // one bit per cycle of flight
    logic [ADDSUB_CYCLES-1:0] vld_pipe;

    logic             a_sign;
    logic             b_sign;
    logic [MAG_W-1:0] a_mag;
    logic [MAG_W-1:0] b_mag;
    logic             sum_sign;
    logic [MAG_W-1:0] sum_mag;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[ADDSUB_CYCLES-2:0], start};
        end
    end

    assign finish = vld_pipe[ADDSUB_CYCLES-1];

    // cycle 1 captures, b sign flipped for subtract
    always_ff @(posedge clk) begin
        if (start) begin
            a_sign <= a[WORD_W-1];
            a_mag  <= a[MAG_W-1:0];
            b_sign <= b[WORD_W-1] ^ sub;
            b_mag  <= b[MAG_W-1:0];
        end
        if (vld_pipe[0]) begin
            result <= {sum_sign, sum_mag};
        end
    end

    // cycle 2 combines
    always_comb begin
        if (a_sign == b_sign) begin
            sum_mag  = a_mag + b_mag;
            sum_sign = a_sign;
        end else if (a_mag >= b_mag) begin
            sum_mag  = a_mag - b_mag;
            sum_sign = a_sign;
        end else begin
            sum_mag  = b_mag - a_mag;
            sum_sign = b_sign;
        end
        // zero is always positive
        if (sum_mag == '0) begin
            sum_sign = 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (!nRST) vld_pipe[0] |-> !start)
        else $error("sm_addsub started while an operation is in flight");

endmodule

// ==== common/calc_pkg.sv ====
// calculator shared definitions: FSM states, key codes and word widths
package calc_pkg;

    // sign-magnitude word, top bit is the sign
    localparam int WORD_W = 16;
    localparam int MAG_W = 15;

    // one keypad digit
    localparam int DIGIT_W = 4;

    // decimal shift applied before each new digit
    localparam int DIGIT_BASE = 10;

    // unit latencies, start cycle to finish cycle
    localparam int MULT_CYCLES = 16;
    localparam int ADDSUB_CYCLES = 2;

    // multiplier step counter width
    localparam int MULT_CNT_W = $clog2(MULT_CYCLES);

    typedef enum logic [3:0] {
        ENTER_OP1,
        WAIT_SHIFT_OP1,
        ADD_DIGIT_OP1,
        ENTER_OP2,
        WAIT_SHIFT_OP2,
        ADD_DIGIT_OP2,
        DISPATCH,
        WAIT_UNIT,
        SHOW_RESULT
    } calc_state_t;

    // operator key codes as driven by the keypad
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } calc_op_t;

endpackage
